/* vlog.f */
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_lru.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/tb_main_memory.sv
sim/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/dcache_tag_store.sv
      - design/dcache_data_store.sv
      - design/dcache_lru.sv
      - design/dcache_ctrl.sv
      - design/dcache_top.sv
  - target: simulation
    files:
      - sim/tb_main_memory.sv
      - sim/tb_dcache.sv

/* sim/tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int WAY_CNT     = 4;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RANDOM_OPS  = 300;
    localparam int TOTAL_OPS   = RANDOM_OPS + 2 * WAY_CNT;
    localparam int WATCHDOG_NS = (TOTAL_OPS * 60 + 8) * CLK_PERIOD;
    localparam int LINE_NUM_W  = TAG_W + SET_W;
    localparam int LINE_LSB    = LINE_OFF_W + WORD_OFF_W;
    localparam int LINES       = 1 << LINE_NUM_W;
    localparam int DIR_TAG     = 900;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic        request_finish;
    logic [31:0] read_data;
    logic        mem_read_request;
    logic        mem_write_request;
    logic [31:0] mem_addr;
    mem_line_t   mem_write_data;
    logic        mem_request_finish;
    mem_line_t   mem_read_data;
    logic [2:0]  mem_delay;

    logic [31:0] lcg_state;
    logic [31:0] gold_mem [LINES * LINE_WORDS];
    logic        fetched [LINES];
    logic        expect_read_q;
    logic [31:0] last_wb_addr;

    dcache_top #(
        .WAY_CNT (WAY_CNT)
    ) dcache_top_i (
        .clk                (clk),
        .rst                (rst),
        .cpu_req            (cpu_req),
        .request_finish     (request_finish),
        .read_data          (read_data),
        .mem_read_request   (mem_read_request),
        .mem_write_request  (mem_write_request),
        .mem_addr           (mem_addr),
        .mem_write_data     (mem_write_data),
        .mem_request_finish (mem_request_finish),
        .mem_read_data      (mem_read_data)
    );

    tb_main_memory main_memory_i (
        .clk                (clk),
        .delay              (mem_delay),
        .mem_read_request   (mem_read_request),
        .mem_write_request  (mem_write_request),
        .mem_addr           (mem_addr),
        .mem_write_data     (mem_write_data),
        .mem_request_finish (mem_request_finish),
        .mem_read_data      (mem_read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word,
                                              input int byte_sel);
        addr_fields_t a;
        a          = '0;
        a.tag      = TAG_W'(tag);
        a.set      = SET_W'(set);
        a.word_off = LINE_OFF_W'(word);
        a.byte_off = WORD_OFF_W'(byte_sel);
        return a;
    endfunction

    // byte offset 0 is the top byte of a big-endian word
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [2:0] st,
                                                input logic [1:0] off, input logic [31:0] wdata);
        logic [31:0] w;
        w = old;
        if (st == 3'd0)
            w[(3 - off) * 8 +: 8] = wdata[7:0];
        else if (st == 3'd1)
        begin
            if (off[1])
                w[15:0] = wdata[15:0];
            else
                w[31:16] = wdata[15:0];
        end
        else if (st == 3'd2)
            w = wdata;
        return w;
    endfunction

    function automatic mem_line_t golden_line(input logic [LINE_NUM_W-1:0] line);
        mem_line_t l;
        for (int w = 0; w < LINE_WORDS; w++)
            l[w] = gold_mem[line * LINE_WORDS + w];
        return l;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual)
            fail_run($sformatf("[ERROR] %s: expected %0h, got %0h", name, expected, actual));
    endtask

    // one CPU request is held until the finish pulse and over the following edge
    task automatic do_access(input logic is_write, input logic [2:0] st,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic stay_local);
        logic [15:0] idx;
        logic        done;
        idx  = addr[17:2];
        done = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req.read       = !is_write;
        cpu_req.write      = is_write;
        cpu_req.store_type = store_type_e'(st);
        cpu_req.addr       = addr;
        cpu_req.wdata      = wdata;
        mem_delay          = 3'(lcg_next() % 4 + 1);
        while (!done)
        begin
            @(negedge clk);
            if (stay_local && (mem_read_request || mem_write_request))
                fail_run("memory request issued for a line that should hit");
            done = request_finish;
        end
        if (is_write)
            gold_mem[idx] = merge_store(gold_mem[idx], st, addr[1:0], wdata);
        else
            check_value("read_data", gold_mem[idx], read_data);
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
        @(negedge clk);
        check_value("request_finish", 1'b0, request_finish);
        check_value("read_data", 32'h0, read_data);
    endtask

    // memory side monitor samples away from the clock edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (mem_read_request && mem_write_request)
                fail_run("both memory requests are high at once");
            if (expect_read_q)
                check_value("mem_read_request", 1'b1, mem_read_request);
            expect_read_q = mem_write_request && mem_request_finish;
            if (mem_write_request)
            begin
                check_value("mem_addr", 5'h0, mem_addr[LINE_LSB-1:0]);
                if (!fetched[mem_addr[LINE_LSB +: LINE_NUM_W]])
                    fail_run("write-back of a line that was never read from memory");
                check_value("mem_write_data", golden_line(mem_addr[LINE_LSB +: LINE_NUM_W]),
                            mem_write_data);
                last_wb_addr = mem_addr;
            end
            if (mem_read_request)
            begin
                check_value("mem_addr", 5'h0, mem_addr[LINE_LSB-1:0]);
                if (mem_request_finish)
                    fetched[mem_addr[LINE_LSB +: LINE_NUM_W]] = 1'b1;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired, the cache stopped finishing requests");
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] addr;
        logic        is_write;
        logic        local_op;
        int          tag;
        int          set;
        clk           = 1'b0;
        rst           = 1'b1;
        cpu_req       = '0;
        mem_delay     = 3'd1;
        lcg_state     = 32'd40;
        expect_read_q = 1'b0;
        last_wb_addr  = '0;
        tag           = 0;
        set           = 0;
        // golden view starts equal to the memory fill
        for (int i = 0; i < LINES * LINE_WORDS; i++)
            gold_mem[i] = {16'(i), ~16'(i)};
        for (int l = 0; l < LINES; l++)
            fetched[l] = 1'b0;

        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_value("request_finish", 1'b0, request_finish);
        check_value("mem_read_request", 1'b0, mem_read_request);
        check_value("mem_write_request", 1'b0, mem_write_request);
        check_value("mem_addr", 32'h0, mem_addr);

        // fill every way of set 0 in order, touch all but the first, then force an eviction
        for (int k = 0; k < WAY_CNT; k++)
            do_access(1'b1, ST_WORD, make_addr(DIR_TAG + k, 0, k, 0), lcg_next(), 1'b0);
        for (int k = 1; k < WAY_CNT; k++)
            do_access(1'b0, ST_WORD, make_addr(DIR_TAG + k, 0, k, 0), 32'h0, 1'b1);
        last_wb_addr = '1;
        do_access(1'b0, ST_WORD, make_addr(DIR_TAG + WAY_CNT, 0, 0, 0), 32'h0, 1'b0);
        check_value("mem_addr", make_addr(DIR_TAG, 0, 0, 0), last_wb_addr);

        // 4 sets x 12 tags keeps conflicts and dirty evictions frequent
        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            r        = lcg_next();
            local_op = (n != 0) && (r % 5 == 0);
            if (!local_op)
            begin
                tag = int'(lcg_next() % 12) * 37;
                set = int'(lcg_next() % 4) * 2;
            end
            addr     = make_addr(tag, set, int'(lcg_next() % 8), int'(lcg_next() % 4));
            is_write = (lcg_next() % 2) == 1;
            hi       = lcg_next();
            lo       = lcg_next();
            do_access(is_write, 3'(lcg_next() % 4), addr, {hi[15:0], lo[15:0]}, local_op);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sim/tb_main_memory.sv */
`timescale 1ns/100ps

module tb_main_memory (
    input  logic                  clk,
    input  logic [2:0]            delay,
    input  logic                  mem_read_request,
    input  logic                  mem_write_request,
    input  logic [31:0]           mem_addr,
    input  dcache_pkg::mem_line_t mem_write_data,
    output logic                  mem_request_finish,
    output dcache_pkg::mem_line_t mem_read_data
);
    import dcache_pkg::*;

    localparam int LINE_NUM_W  = TAG_W + SET_W;
    localparam int LINE_LSB    = LINE_OFF_W + WORD_OFF_W;
    localparam int LINES       = 1 << LINE_NUM_W;
    localparam int DRIVE_DELAY = 10;

    mem_line_t   lines [LINES];
    int          waited;
    logic [15:0] word_idx;

    // every word starts as its own word index and its inverse
    initial
    begin
        mem_request_finish = 1'b0;
        mem_read_data      = '0;
        waited             = 0;
        for (int l = 0; l < LINES; l++)
        begin
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                word_idx    = 16'(l * LINE_WORDS + w);
                lines[l][w] = {word_idx, ~word_idx};
            end
        end
    end

    // a held request is answered with a one-cycle finish after delay cycles
    always @(posedge clk)
    begin
        #DRIVE_DELAY;
        if (mem_request_finish)
        begin
            mem_request_finish = 1'b0;
            waited             = 0;
        end
        else if (mem_read_request || mem_write_request)
        begin
            waited = waited + 1;
            if (waited >= delay)
            begin
                if (mem_write_request)
                    lines[mem_addr[LINE_LSB +: LINE_NUM_W]] = mem_write_data;
                else
                    mem_read_data = lines[mem_addr[LINE_LSB +: LINE_NUM_W]];
                mem_request_finish = 1'b1;
            end
        end
    end

endmodule

/* design/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top #(
    parameter int WAY_CNT = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  request_finish,
    output logic [31:0]           read_data,
    output logic                  mem_read_request,
    output logic                  mem_write_request,
    output logic [31:0]           mem_addr,
    output dcache_pkg::mem_line_t mem_write_data,
    input  logic                  mem_request_finish,
    input  dcache_pkg::mem_line_t mem_read_data
);
    import dcache_pkg::*;

    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1;

    logic [SET_W-1:0] lookup_set;
    logic [TAG_W-1:0] lookup_tag;
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    logic             victim_valid;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic [WAY_W-1:0] victim_way;
    logic [31:0]      hit_word;
    mem_line_t        victim_line;
    logic             do_store;
    logic             do_refill;
    logic [SET_W-1:0] refill_set;
    logic [WAY_W-1:0] refill_way;
    logic [TAG_W-1:0] refill_tag;
    mem_line_t        refill_line;
    logic             touch;

    dcache_ctrl #(
        .WAY_CNT (WAY_CNT)
    ) dcache_ctrl_i (
        .clk                (clk),
        .rst                (rst),
        .cpu_req            (cpu_req),
        .request_finish     (request_finish),
        .read_data          (read_data),
        .lookup_set         (lookup_set),
        .lookup_tag         (lookup_tag),
        .hit                (hit),
        .hit_way            (hit_way),
        .victim_valid       (victim_valid),
        .victim_dirty       (victim_dirty),
        .victim_tag         (victim_tag),
        .victim_way         (victim_way),
        .hit_word           (hit_word),
        .victim_line        (victim_line),
        .do_store           (do_store),
        .do_refill          (do_refill),
        .refill_set         (refill_set),
        .refill_way         (refill_way),
        .refill_tag         (refill_tag),
        .refill_line        (refill_line),
        .touch              (touch),
        .mem_read_request   (mem_read_request),
        .mem_write_request  (mem_write_request),
        .mem_addr           (mem_addr),
        .mem_write_data     (mem_write_data),
        .mem_request_finish (mem_request_finish),
        .mem_read_data      (mem_read_data)
    );

    dcache_tag_store #(
        .WAY_CNT (WAY_CNT)
    ) dcache_tag_store_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .do_store     (do_store),
        .do_refill    (do_refill),
        .refill_set   (refill_set),
        .refill_way   (refill_way),
        .refill_tag   (refill_tag)
    );

    dcache_data_store #(
        .WAY_CNT (WAY_CNT)
    ) dcache_data_store_i (
        .clk         (clk),
        .cpu_req     (cpu_req),
        .lookup_set  (lookup_set),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .do_store    (do_store),
        .do_refill   (do_refill),
        .refill_set  (refill_set),
        .refill_way  (refill_way),
        .refill_line (refill_line),
        .hit_word    (hit_word),
        .victim_line (victim_line)
    );

    dcache_lru #(
        .WAY_CNT (WAY_CNT)
    ) dcache_lru_i (
        .clk        (clk),
        .rst        (rst),
        .lookup_set (lookup_set),
        .hit_way    (hit_way),
        .touch      (touch),
        .victim_way (victim_way)
    );

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  dcache_pkg::cpu_req_t         cpu_req,
    output logic                         request_finish,
    output logic [31:0]                  read_data,
    output logic [dcache_pkg::SET_W-1:0] lookup_set,
    output logic [dcache_pkg::TAG_W-1:0] lookup_tag,
    input  logic                         hit,
    input  logic [WAY_W-1:0]             hit_way,
    input  logic                         victim_valid,
    input  logic                         victim_dirty,
    input  logic [dcache_pkg::TAG_W-1:0] victim_tag,
    input  logic [WAY_W-1:0]             victim_way,
    input  logic [31:0]                  hit_word,
    input  dcache_pkg::mem_line_t        victim_line,
    output logic                         do_store,
    output logic                         do_refill,
    output logic [dcache_pkg::SET_W-1:0] refill_set,
    output logic [WAY_W-1:0]             refill_way,
    output logic [dcache_pkg::TAG_W-1:0] refill_tag,
    output dcache_pkg::mem_line_t        refill_line,
    output logic                         touch,
    output logic                         mem_read_request,
    output logic                         mem_write_request,
    output logic [31:0]                  mem_addr,
    output dcache_pkg::mem_line_t        mem_write_data,
    input  logic                         mem_request_finish,
    input  dcache_pkg::mem_line_t        mem_read_data
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        READY,
        WRITE_BACK,
        REFILL
    } state_e;

    state_e           state_q;
    logic             guard_q;
    line_addr_t       req_line_q;
    line_addr_t       vic_line_q;
    logic [WAY_W-1:0] victim_way_q;
    logic             accept;

    // line number to line-aligned byte address
    function automatic logic [31:0] line_to_addr(line_addr_t line);
        return 32'({line, {(LINE_OFF_W + WORD_OFF_W){1'b0}}});
    endfunction

    assign lookup_set = cpu_req.addr.set;
    assign lookup_tag = cpu_req.addr.tag;

    // guard masks the cycle right after a finish while the CPU still holds the request
    assign accept   = (state_q == READY) && (cpu_req.read || cpu_req.write) && !guard_q;
    assign touch    = accept && hit;
    // read wins when both strobes are up
    assign do_store = touch && cpu_req.write && !cpu_req.read;

    assign do_refill   = (state_q == REFILL) && mem_request_finish;
    assign refill_set  = req_line_q.set;
    assign refill_tag  = req_line_q.tag;
    // the refill goes to the way chosen when the miss was taken
    assign refill_way  = victim_way_q;
    assign refill_line = mem_read_data;

    assign mem_read_request  = (state_q == REFILL);
    assign mem_write_request = (state_q == WRITE_BACK);

    always_comb
    begin
        if (state_q == REFILL)
            mem_addr = line_to_addr(req_line_q);
        else if (state_q == WRITE_BACK)
            mem_addr = line_to_addr(vic_line_q);
        else
            mem_addr = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q        <= READY;
            guard_q        <= 1'b0;
            request_finish <= 1'b0;
            read_data      <= '0;
        end
        else
        begin
            request_finish <= 1'b0;
            read_data      <= '0;
            guard_q        <= 1'b0;
            case (state_q)
                READY:
                begin
                    if (accept && hit)
                    begin
                        request_finish <= 1'b1;
                        guard_q        <= 1'b1;
                        if (cpu_req.read)
                            read_data <= hit_word;
                    end
                    else if (accept)
                    begin
                        // only a dirty valid victim needs writing back
                        state_q <= (victim_valid && victim_dirty) ? WRITE_BACK : REFILL;
                    end
                end
                WRITE_BACK:
                begin
                    if (mem_request_finish)
                        state_q <= REFILL;
                end
                REFILL:
                begin
                    // the held request then hits on the fresh line
                    if (mem_request_finish)
                        state_q <= READY;
                end
                default:
                    state_q <= READY;
            endcase
        end
    end

    // miss context is captured once when the miss is taken
    always_ff @(posedge clk)
    begin
        if (accept && !hit)
        begin
            req_line_q     <= '{tag: cpu_req.addr.tag, set: cpu_req.addr.set};
            vic_line_q     <= '{tag: victim_tag, set: cpu_req.addr.set};
            victim_way_q   <= victim_way;
            mem_write_data <= victim_line;
        end
    end

endmodule

/* design/dcache_lru.sv */
`timescale 1ns/100ps

module dcache_lru #(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [dcache_pkg::SET_W-1:0] lookup_set,
    input  logic [WAY_W-1:0]             hit_way,
    input  logic                         touch,
    output logic [WAY_W-1:0]             victim_way
);
    import dcache_pkg::*;

    // wide enough that the age order of all ways survives saturation
    localparam int AGE_W = $clog2(WAY_CNT + 1) + 1;
    localparam logic [AGE_W-1:0] MAX_AGE = '1;

    logic [AGE_W-1:0] age_q [SETS][WAY_CNT];
    logic [AGE_W-1:0] oldest_age;

    // strict compare keeps the lowest way among equal ages
    always_comb
    begin
        oldest_age = age_q[lookup_set][0];
        victim_way = '0;
        for (int w = 1; w < WAY_CNT; w++)
        begin
            if (age_q[lookup_set][w] > oldest_age)
            begin
                oldest_age = age_q[lookup_set][w];
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAY_CNT; w++)
                    age_q[s][w] <= MAX_AGE;
            end
        end
        else if (touch)
        begin
            for (int w = 0; w < WAY_CNT; w++)
            begin
                if (WAY_W'(w) == hit_way)
                    age_q[lookup_set][w] <= '0;
                else if (age_q[lookup_set][w] < MAX_AGE)
                    age_q[lookup_set][w] <= age_q[lookup_set][w] + 1'b1;
            end
        end
    end

endmodule

/* design/dcache_data_store.sv */
`timescale 1ns/100ps

module dcache_data_store #(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
) (
    input  logic                         clk,
    input  dcache_pkg::cpu_req_t         cpu_req,
    input  logic [dcache_pkg::SET_W-1:0] lookup_set,
    input  logic [WAY_W-1:0]             hit_way,
    input  logic [WAY_W-1:0]             victim_way,
    input  logic                         do_store,
    input  logic                         do_refill,
    input  logic [dcache_pkg::SET_W-1:0] refill_set,
    input  logic [WAY_W-1:0]             refill_way,
    input  dcache_pkg::mem_line_t        refill_line,
    output logic [31:0]                  hit_word,
    output dcache_pkg::mem_line_t        victim_line
);
    import dcache_pkg::*;

    mem_line_t   line_q [SETS][WAY_CNT];
    logic [31:0] merged_word;

    assign hit_word    = line_q[lookup_set][hit_way][cpu_req.addr.word_off];
    assign victim_line = line_q[lookup_set][victim_way];

    // big-endian lanes put byte offset 0 in bits 31:24
    always_comb
    begin
        merged_word = hit_word;
        case (cpu_req.store_type)
            ST_BYTE:
            begin
                case (cpu_req.addr.byte_off)
                    2'd0: merged_word[31:24] = cpu_req.wdata[7:0];
                    2'd1: merged_word[23:16] = cpu_req.wdata[7:0];
                    2'd2: merged_word[15:8]  = cpu_req.wdata[7:0];
                    default: merged_word[7:0] = cpu_req.wdata[7:0];
                endcase
            end
            ST_HALF:
            begin
                if (cpu_req.addr.byte_off[1])
                    merged_word[15:0] = cpu_req.wdata[15:0];
                else
                    merged_word[31:16] = cpu_req.wdata[15:0];
            end
            ST_WORD:
            begin
                merged_word = cpu_req.wdata;
            end
            default:
            begin
                // unknown store type leaves the word alone
                merged_word = hit_word;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (do_store)
            line_q[lookup_set][hit_way][cpu_req.addr.word_off] <= merged_word;
        if (do_refill)
            line_q[refill_set][refill_way] <= refill_line;
    end

endmodule

/* design/dcache_tag_store.sv */
`timescale 1ns/100ps

module dcache_tag_store #(
    parameter int WAY_CNT = 4,
    localparam int WAY_W = (WAY_CNT > 1) ? $clog2(WAY_CNT) : 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [dcache_pkg::SET_W-1:0] lookup_set,
    input  logic [dcache_pkg::TAG_W-1:0] lookup_tag,
    input  logic [WAY_W-1:0]             victim_way,
    output logic                         hit,
    output logic [WAY_W-1:0]             hit_way,
    output logic                         victim_valid,
    output logic                         victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0] victim_tag,
    input  logic                         do_store,
    input  logic                         do_refill,
    input  logic [dcache_pkg::SET_W-1:0] refill_set,
    input  logic [WAY_W-1:0]             refill_way,
    input  logic [dcache_pkg::TAG_W-1:0] refill_tag
);
    import dcache_pkg::*;

    logic [TAG_W-1:0] tag_q   [SETS][WAY_CNT];
    logic             valid_q [SETS][WAY_CNT];
    logic             dirty_q [SETS][WAY_CNT];

    // the highest matching way of the set wins
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAY_CNT; w++)
        begin
            if (valid_q[lookup_set][w] && (tag_q[lookup_set][w] == lookup_tag))
            begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign victim_valid = valid_q[lookup_set][victim_way];
    assign victim_dirty = dirty_q[lookup_set][victim_way];
    assign victim_tag   = tag_q[lookup_set][victim_way];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAY_CNT; w++)
                begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end
        else
        begin
            if (do_store)
                dirty_q[lookup_set][hit_way] <= 1'b1;
            // fresh line from memory is clean
            if (do_refill)
            begin
                valid_q[refill_set][refill_way] <= 1'b1;
                dirty_q[refill_set][refill_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_refill)
            tag_q[refill_set][refill_way] <= refill_tag;
    end

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int WORD_OFF_W = 2;
    localparam int LINE_OFF_W = 3;
    localparam int LINE_WORDS = 1 << LINE_OFF_W;
    localparam int SET_W      = 3;
    localparam int SETS       = 1 << SET_W;
    localparam int TAG_W      = 10;

    // address bits above the tag are not decoded
    localparam int UNUSED_W = 32 - TAG_W - SET_W - LINE_OFF_W - WORD_OFF_W;

    // any other store width is a no-op store
    typedef enum logic [2:0] {
        ST_BYTE = 3'd0,
        ST_HALF = 3'd1,
        ST_WORD = 3'd2
    } store_type_e;

    typedef struct packed {
        logic [UNUSED_W-1:0]   unused;
        logic [TAG_W-1:0]      tag;
        logic [SET_W-1:0]      set;
        logic [LINE_OFF_W-1:0] word_off;
        logic [WORD_OFF_W-1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        logic         read;
        logic         write;
        store_type_e  store_type;
        addr_fields_t addr;
        logic [31:0]  wdata;
    } cpu_req_t;

    // word 0 sits in the top 32 bits
    typedef logic [0:LINE_WORDS-1][31:0] mem_line_t;

    // line number in memory
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] set;
    } line_addr_t;

endpackage
